/* common/rvFrontPkg.sv */
package rvFrontPkg;

    // ==============================
    // Widths and reset values
    // ==============================
    localparam int xlen = 32;
    localparam int regAddrW = 5;
    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

    // ==============================
    // Encodings
    // ==============================

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad     = 7'b0000011,
        opFence    = 7'b0001111,
        opArithImm = 7'b0010011,
        opAuipc    = 7'b0010111,
        opStore    = 7'b0100011,
        opArith    = 7'b0110011,
        opLui      = 7'b0110111,
        opBranch   = 7'b1100011,
        opJalr     = 7'b1100111,
        opJal      = 7'b1101111,
        opSystem   = 7'b1110011
    } opcodeE;

    // Execute stage operations
    typedef enum logic [4:0] {
        aluNop = 5'd0,   // Zero so an empty control word is a bubble
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB,        // lui result is the immediate
        aluBeq,
        aluBne,
        aluBlt,
        aluBge,
        aluBltu,
        aluBgeu
    } aluOpE;

    // Load data width and sign extension
    typedef enum logic [2:0] {
        extNone = 3'd0,
        extByte,
        extHalf,
        extWord,
        extByteU,
        extHalfU
    } loadExtE;

    // ==============================
    // Bundles
    // ==============================

    // Microcoded control word, 16 bits
    typedef struct packed {
        aluOpE   aluOp;
        logic    srcAPc;     // Operand A from PC
        logic    srcBImm;    // Operand B from immediate
        loadExtE loadExt;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        logic    memToReg;
        logic    branch;
        logic    jump;
    } ctrlT;

    // Fetch unit output
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } fetchT;

    // One decoded instruction for execute
    typedef struct packed {
        logic                valid;
        logic                illegal;
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     rs1Data;
        logic [xlen-1:0]     rs2Data;
        ctrlT                ctrl;
    } decodedT;

    // Writeback port into the register file
    typedef struct packed {
        logic                en;
        logic [regAddrW-1:0] addr;
        logic [xlen-1:0]     data;
    } regWriteT;

endpackage

/* fetch/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [rvFrontPkg::xlen-1:0] redirectPc,
    output rvFrontPkg::fetchT           fetch
);

    logic [rvFrontPkg::xlen-1:0] pcNext;

    // Next PC select
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;              // Redirect wins over stall
        end else if (stall || !fetch.valid) begin
            pcNext = fetch.pc;                // Hold, also on the first edge out of reset
        end else begin
            pcNext = fetch.pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetch.valid <= 1'b0;
            fetch.pc    <= rvFrontPkg::resetPc;
        end else begin
            fetch.valid <= 1'b1;
            fetch.pc    <= pcNext;
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Branch targets from execute are word aligned
    redirectAlignedA : assert property (
        @(posedge clk) disable iff (!arstN)
        redirect |-> (redirectPc[1:0] == 2'b00)
    ) else $error("redirectPc not word aligned: %h", redirectPc);

endmodule

/* decode/immGen.sv */
`timescale 1ns/1ps

module immGen (
    input  logic [rvFrontPkg::xlen-1:0] instr,
    output logic [rvFrontPkg::xlen-1:0] imm
);

    logic isShiftImm;

    // slli, srli and srai carry funct3 001 or 101
    assign isShiftImm = ~instr[13] & instr[12];

    always_comb begin
        case (instr[6:0])
            rvFrontPkg::opLoad,
            rvFrontPkg::opJalr: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rvFrontPkg::opArithImm: begin
                if (isShiftImm) begin
                    imm = {27'd0, instr[24:20]};   // shamt only
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
            rvFrontPkg::opStore: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rvFrontPkg::opBranch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvFrontPkg::opLui,
            rvFrontPkg::opAuipc: begin
                imm = {instr[31:12], 12'd0};
            end
            rvFrontPkg::opJal: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;                          // R-type, fence, system
            end
        endcase
    end

endmodule

/* decode/controller.sv */
`timescale 1ns/1ps

module controller (
    input  logic [rvFrontPkg::xlen-1:0] instr,
    output rvFrontPkg::ctrlT            ctrl,
    output logic                        illegal
);

    // How much of the instruction selects the table row
    typedef enum logic [1:0] {
        keyOp,
        keyF3Op,
        keyF7F3Op
    } keyClassE;

    keyClassE    keyClass;
    logic [16:0] key;       // {funct7, funct3, opcode}
    logic        isShiftImm;

    // flags is {srcAPc, srcBImm, memRead, memWrite, regWrite, memToReg, branch, jump}
    function automatic rvFrontPkg::ctrlT row(
        input rvFrontPkg::aluOpE   op,
        input logic [7:0]          flags,
        input rvFrontPkg::loadExtE ext = rvFrontPkg::extNone
    );
        return {op, flags[7:6], ext, flags[5:0]};
    endfunction

    assign isShiftImm = ~instr[13] & instr[12];

    // Step 1, classify the opcode
    always_comb begin
        case (instr[6:0])
            rvFrontPkg::opLui, rvFrontPkg::opAuipc, rvFrontPkg::opJal: keyClass = keyOp;
            rvFrontPkg::opLoad, rvFrontPkg::opStore, rvFrontPkg::opBranch,
            rvFrontPkg::opJalr, rvFrontPkg::opFence, rvFrontPkg::opSystem: keyClass = keyF3Op;
            rvFrontPkg::opArithImm: keyClass = isShiftImm ? keyF7F3Op : keyF3Op;
            default: keyClass = keyF7F3Op;    // R-type and unknown opcodes
        endcase

        case (keyClass)
            keyOp:   key = {7'h00, 3'h0, instr[6:0]};
            keyF3Op: key = {7'h00, instr[14:12], instr[6:0]};
            default: key = {instr[31:25], instr[14:12], instr[6:0]};
        endcase
    end

    // ==============================
    // Microcode table
    // ==============================
    always_comb begin
        illegal = 1'b0;
        case (key)
            {7'h00, 3'h0, rvFrontPkg::opLui}     : ctrl = row(rvFrontPkg::aluPassB, 8'b01001000);
            {7'h00, 3'h0, rvFrontPkg::opAuipc}   : ctrl = row(rvFrontPkg::aluAdd, 8'b11001000);
            {7'h00, 3'h0, rvFrontPkg::opJal}     : ctrl = row(rvFrontPkg::aluAdd, 8'b11001001);
            {7'h00, 3'h0, rvFrontPkg::opJalr}    : ctrl = row(rvFrontPkg::aluAdd, 8'b01001001);
            // Branches compare rs1 against rs2
            {7'h00, 3'h0, rvFrontPkg::opBranch}  : ctrl = row(rvFrontPkg::aluBeq, 8'b00000010);
            {7'h00, 3'h1, rvFrontPkg::opBranch}  : ctrl = row(rvFrontPkg::aluBne, 8'b00000010);
            {7'h00, 3'h4, rvFrontPkg::opBranch}  : ctrl = row(rvFrontPkg::aluBlt, 8'b00000010);
            {7'h00, 3'h5, rvFrontPkg::opBranch}  : ctrl = row(rvFrontPkg::aluBge, 8'b00000010);
            {7'h00, 3'h6, rvFrontPkg::opBranch}  : ctrl = row(rvFrontPkg::aluBltu, 8'b00000010);
            {7'h00, 3'h7, rvFrontPkg::opBranch}  : ctrl = row(rvFrontPkg::aluBgeu, 8'b00000010);
            // Loads
            {7'h00, 3'h0, rvFrontPkg::opLoad}    : ctrl = row(rvFrontPkg::aluAdd, 8'b01101100,
                                                              rvFrontPkg::extByte);
            {7'h00, 3'h1, rvFrontPkg::opLoad}    : ctrl = row(rvFrontPkg::aluAdd, 8'b01101100,
                                                              rvFrontPkg::extHalf);
            {7'h00, 3'h2, rvFrontPkg::opLoad}    : ctrl = row(rvFrontPkg::aluAdd, 8'b01101100,
                                                              rvFrontPkg::extWord);
            {7'h00, 3'h4, rvFrontPkg::opLoad}    : ctrl = row(rvFrontPkg::aluAdd, 8'b01101100,
                                                              rvFrontPkg::extByteU);
            {7'h00, 3'h5, rvFrontPkg::opLoad}    : ctrl = row(rvFrontPkg::aluAdd, 8'b01101100,
                                                              rvFrontPkg::extHalfU);
            // Stores, width is funct3 passed through to memory
            {7'h00, 3'h0, rvFrontPkg::opStore}   : ctrl = row(rvFrontPkg::aluAdd, 8'b01010000);
            {7'h00, 3'h1, rvFrontPkg::opStore}   : ctrl = row(rvFrontPkg::aluAdd, 8'b01010000);
            {7'h00, 3'h2, rvFrontPkg::opStore}   : ctrl = row(rvFrontPkg::aluAdd, 8'b01010000);
            // Register-immediate
            {7'h00, 3'h0, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluAdd, 8'b01001000);
            {7'h00, 3'h2, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluSlt, 8'b01001000);
            {7'h00, 3'h3, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluSltu, 8'b01001000);
            {7'h00, 3'h4, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluXor, 8'b01001000);
            {7'h00, 3'h6, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluOr, 8'b01001000);
            {7'h00, 3'h7, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluAnd, 8'b01001000);
            {7'h00, 3'h1, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluSll, 8'b01001000);
            {7'h00, 3'h5, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluSrl, 8'b01001000);
            {7'h20, 3'h5, rvFrontPkg::opArithImm}: ctrl = row(rvFrontPkg::aluSra, 8'b01001000);
            // Register-register
            {7'h00, 3'h0, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluAdd, 8'b00001000);
            {7'h20, 3'h0, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluSub, 8'b00001000);
            {7'h00, 3'h1, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluSll, 8'b00001000);
            {7'h00, 3'h2, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluSlt, 8'b00001000);
            {7'h00, 3'h3, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluSltu, 8'b00001000);
            {7'h00, 3'h4, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluXor, 8'b00001000);
            {7'h00, 3'h5, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluSrl, 8'b00001000);
            {7'h20, 3'h5, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluSra, 8'b00001000);
            {7'h00, 3'h6, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluOr, 8'b00001000);
            {7'h00, 3'h7, rvFrontPkg::opArith}   : ctrl = row(rvFrontPkg::aluAnd, 8'b00001000);
            // fence, ecall and ebreak are legal no-ops here
            {7'h00, 3'h0, rvFrontPkg::opFence}   : ctrl = row(rvFrontPkg::aluNop, 8'b00000000);
            {7'h00, 3'h0, rvFrontPkg::opSystem}  : ctrl = row(rvFrontPkg::aluNop, 8'b00000000);
            default: begin
                ctrl    = row(rvFrontPkg::aluNop, 8'b00000000);
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* decode/fetchDecode.sv */
`timescale 1ns/1ps

module fetchDecode (
    input  logic                            clk,
    input  logic                            arstN,
    input  rvFrontPkg::fetchT               fetch,
    input  logic [rvFrontPkg::xlen-1:0]     instr,
    input  logic                            stall,
    input  logic                            redirect,
    output logic [rvFrontPkg::regAddrW-1:0] rs1Addr,
    output logic [rvFrontPkg::regAddrW-1:0] rs2Addr,
    input  logic [rvFrontPkg::xlen-1:0]     rs1Data,
    input  logic [rvFrontPkg::xlen-1:0]     rs2Data,
    output rvFrontPkg::decodedT             decoded
);

    logic [rvFrontPkg::xlen-1:0] imm;
    rvFrontPkg::ctrlT            ctrl;
    logic                        illegal;
    rvFrontPkg::decodedT         bundle;

    immGen immGen_i (
        .instr (instr),
        .imm   (imm)
    );

    controller controller_i (
        .instr   (instr),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    // Register fields feed the register file directly
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    // Wrong-path instruction becomes a bubble on redirect
    always_comb begin
        bundle = '{
            valid:   fetch.valid & ~redirect,
            illegal: illegal,
            pc:      fetch.pc,
            rd:      instr[11:7],
            imm:     imm,
            rs1Data: rs1Data,
            rs2Data: rs2Data,
            ctrl:    ctrl
        };
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decoded <= '0;
        end else if (redirect || !stall) begin
            decoded <= bundle;                // Stall alone holds every field
        end
    end

    // ==============================
    // Checks
    // ==============================
    stallHoldA : assert property (
        @(posedge clk) disable iff (!arstN)
        (stall && !redirect) |=> $stable(decoded)
    ) else $error("decoded changed across a stalled edge");

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [rvFrontPkg::regAddrW-1:0] rs1Addr,
    input  logic [rvFrontPkg::regAddrW-1:0] rs2Addr,
    input  rvFrontPkg::regWriteT            regWr,
    output logic [rvFrontPkg::xlen-1:0]     rs1Data,
    output logic [rvFrontPkg::xlen-1:0]     rs2Data
);

    logic [rvFrontPkg::xlen-1:0] regs [1:31];   // x0 has no storage

    // x0 reads zero, a same-cycle write is forwarded
    function automatic logic [rvFrontPkg::xlen-1:0] readReg(
        input logic [rvFrontPkg::regAddrW-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (regWr.en && (regWr.addr == addr)) begin
            return regWr.data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rs1Data = readReg(rs1Addr);
        rs2Data = readReg(rs2Addr);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWr.en && (regWr.addr != '0)) begin
            regs[regWr.addr] <= regWr.data;
        end
    end

    // Writeback must name a real register
    writeAddrKnownA : assert property (
        @(posedge clk) disable iff (!arstN)
        regWr.en |-> !$isunknown(regWr.addr)
    ) else $error("register write with unknown address");

endmodule

/* logic/frontEnd.sv */
`timescale 1ns/1ps

module frontEnd (
    input  logic                        clk,
    input  logic                        arstN,
    output logic [rvFrontPkg::xlen-1:0] imemAddr,
    input  logic [rvFrontPkg::xlen-1:0] imemData,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [rvFrontPkg::xlen-1:0] redirectPc,
    input  rvFrontPkg::regWriteT        regWr,
    output rvFrontPkg::decodedT         decoded
);

    rvFrontPkg::fetchT                   fetch;
    logic [rvFrontPkg::regAddrW-1:0]     rs1Addr;
    logic [rvFrontPkg::regAddrW-1:0]     rs2Addr;
    logic [rvFrontPkg::xlen-1:0]         rs1Data;
    logic [rvFrontPkg::xlen-1:0]         rs2Data;

    assign imemAddr = fetch.pc;   // Memory answers in the same cycle

    fetchUnit fetchUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetch      (fetch)
    );

    fetchDecode fetchDecode_i (
        .clk      (clk),
        .arstN    (arstN),
        .fetch    (fetch),
        .instr    (imemData),
        .stall    (stall),
        .redirect (redirect),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .decoded  (decoded)
    );

    regFile regFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .regWr   (regWr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

endmodule

/* verification/frontEndTb.sv */
`timescale 1ns/1ps

module frontEndTb;

    localparam int warmCycles = 20;
    localparam int randCycles = 400;
    localparam int drainCycles = 4;
    localparam int cycleLimit = 4 * (warmCycles + randCycles + drainCycles) + 200;

    logic                 clk = 1'b0;
    logic                 arstN;
    logic [31:0]          imemAddr;
    logic [31:0]          imemData;
    logic                 stall;
    logic                 redirect;
    logic [31:0]          redirectPc;
    rvFrontPkg::regWriteT regWr;
    rvFrontPkg::decodedT  decoded;

    logic [31:0]         imem [0:255];
    logic [31:0]         shadow [0:31];
    rvFrontPkg::decodedT expQ [$];
    rvFrontPkg::decodedT prevDec;
    integer              seed = 32'hdbce;
    int                  cycles = 0;
    int                  checkedCount = 0;
    logic                fetchValid;
    logic [31:0]         expPc;
    int                  lastKind;     // 0 bubble, 1 capture, 2 hold

    frontEnd dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .regWr      (regWr),
        .decoded    (decoded)
    );

    assign imemData = imem[imemAddr[9:2]];   // Combinational instruction memory

    always #4 clk = ~clk;

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [31:0] refImm(input logic [31:0] ins);
        case (ins[6:0])
            rvFrontPkg::opLoad, rvFrontPkg::opJalr: return {{20{ins[31]}}, ins[31:20]};
            rvFrontPkg::opArithImm: begin
                if (ins[14:12] == 3'd1 || ins[14:12] == 3'd5) begin
                    return {27'd0, ins[24:20]};
                end
                return {{20{ins[31]}}, ins[31:20]};
            end
            rvFrontPkg::opStore: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            rvFrontPkg::opBranch:
                return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            rvFrontPkg::opLui, rvFrontPkg::opAuipc: return {ins[31:12], 12'd0};
            rvFrontPkg::opJal: return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return 32'd0;
        endcase
    endfunction

    function automatic rvFrontPkg::ctrlT refCtrl(input logic [31:0] ins, output logic ill);
        rvFrontPkg::ctrlT c;
        logic [2:0] f3;
        logic [6:0] f7;
        c = '0;
        ill = 1'b0;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            rvFrontPkg::opLui: begin
                c.aluOp = rvFrontPkg::aluPassB;
                c.srcBImm = 1'b1;
                c.regWrite = 1'b1;
            end
            rvFrontPkg::opAuipc, rvFrontPkg::opJal: begin
                c.aluOp = rvFrontPkg::aluAdd;
                c.srcAPc = 1'b1;
                c.srcBImm = 1'b1;
                c.regWrite = 1'b1;
                c.jump = (ins[6:0] == rvFrontPkg::opJal);
            end
            rvFrontPkg::opJalr: begin
                ill = (f3 != 3'd0);
                c.aluOp = rvFrontPkg::aluAdd;
                c.srcBImm = 1'b1;
                c.regWrite = 1'b1;
                c.jump = 1'b1;
            end
            rvFrontPkg::opBranch: begin
                c.branch = 1'b1;
                case (f3)
                    3'd0: c.aluOp = rvFrontPkg::aluBeq;
                    3'd1: c.aluOp = rvFrontPkg::aluBne;
                    3'd4: c.aluOp = rvFrontPkg::aluBlt;
                    3'd5: c.aluOp = rvFrontPkg::aluBge;
                    3'd6: c.aluOp = rvFrontPkg::aluBltu;
                    3'd7: c.aluOp = rvFrontPkg::aluBgeu;
                    default: ill = 1'b1;
                endcase
            end
            rvFrontPkg::opLoad: begin
                c.aluOp = rvFrontPkg::aluAdd;
                c.srcBImm = 1'b1;
                c.memRead = 1'b1;
                c.regWrite = 1'b1;
                c.memToReg = 1'b1;
                case (f3)
                    3'd0: c.loadExt = rvFrontPkg::extByte;
                    3'd1: c.loadExt = rvFrontPkg::extHalf;
                    3'd2: c.loadExt = rvFrontPkg::extWord;
                    3'd4: c.loadExt = rvFrontPkg::extByteU;
                    3'd5: c.loadExt = rvFrontPkg::extHalfU;
                    default: ill = 1'b1;
                endcase
            end
            rvFrontPkg::opStore: begin
                ill = (f3 > 3'd2);
                c.aluOp = rvFrontPkg::aluAdd;
                c.srcBImm = 1'b1;
                c.memWrite = 1'b1;
            end
            rvFrontPkg::opArithImm, rvFrontPkg::opArith: begin
                c.srcBImm = (ins[6:0] == rvFrontPkg::opArithImm);
                c.regWrite = 1'b1;
                // Only shifts and R-type look at funct7
                if ((c.srcBImm && f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00) begin
                    case (f3)
                        3'd0: c.aluOp = rvFrontPkg::aluAdd;
                        3'd1: c.aluOp = rvFrontPkg::aluSll;
                        3'd2: c.aluOp = rvFrontPkg::aluSlt;
                        3'd3: c.aluOp = rvFrontPkg::aluSltu;
                        3'd4: c.aluOp = rvFrontPkg::aluXor;
                        3'd5: c.aluOp = rvFrontPkg::aluSrl;
                        3'd6: c.aluOp = rvFrontPkg::aluOr;
                        default: c.aluOp = rvFrontPkg::aluAnd;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    c.aluOp = rvFrontPkg::aluSra;
                end else if (f7 == 7'h20 && f3 == 3'd0 && !c.srcBImm) begin
                    c.aluOp = rvFrontPkg::aluSub;
                end else begin
                    ill = 1'b1;
                end
            end
            rvFrontPkg::opFence, rvFrontPkg::opSystem: ill = (f3 != 3'd0);
            default: ill = 1'b1;
        endcase
        if (ill) begin
            c = '0;
        end
        return c;
    endfunction

    function automatic logic [31:0] refRead(input logic [4:0] a, input rvFrontPkg::regWriteT w);
        if (a == 5'd0) begin
            return 32'd0;
        end
        return (w.en && w.addr == a) ? w.data : shadow[a];
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stopOnError($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkCtrl(input string name, input rvFrontPkg::ctrlT exp,
                             input rvFrontPkg::ctrlT act);
        if (act !== exp) begin
            stopOnError($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkDecoded(input rvFrontPkg::decodedT exp, input rvFrontPkg::decodedT act);
        checkWord("decoded.valid", 32'(exp.valid), 32'(act.valid));
        checkWord("decoded.illegal", 32'(exp.illegal), 32'(act.illegal));
        checkWord("decoded.pc", exp.pc, act.pc);
        checkWord("decoded.rd", 32'(exp.rd), 32'(act.rd));
        checkWord("decoded.imm", exp.imm, act.imm);
        checkWord("decoded.rs1Data", exp.rs1Data, act.rs1Data);
        checkWord("decoded.rs2Data", exp.rs2Data, act.rs2Data);
        checkCtrl("decoded.ctrl", exp.ctrl, act.ctrl);
    endtask

    // Compare the last edge's result, then predict the next edge
    always @(negedge clk) begin
        rvFrontPkg::decodedT e;
        logic [31:0] ins;
        logic ill;
        if (!arstN) begin
            checkWord("imemAddr", rvFrontPkg::resetPc, imemAddr);
            checkWord("decoded.valid", 32'd0, 32'(decoded.valid));
            checkCtrl("decoded.ctrl", '0, decoded.ctrl);
            fetchValid = 1'b0;
            expPc = rvFrontPkg::resetPc;
            lastKind = 0;
        end else begin
            checkWord("imemAddr", expPc, imemAddr);
            if (lastKind == 2) begin
                checkDecoded(prevDec, decoded);
            end else if (decoded.valid !== 1'b1) begin
                checkWord("decoded.valid", 32'(lastKind == 1), 32'(decoded.valid));
            end else if (expQ.size() == 0) begin
                stopOnError("a valid decoded bundle arrived with nothing expected");
            end else begin
                checkDecoded(expQ.pop_front(), decoded);
                checkedCount++;
            end
            prevDec = decoded;
            ins = imem[expPc[9:2]];
            if (redirect) begin
                lastKind = 0;
            end else if (stall) begin
                lastKind = 2;
            end else if (fetchValid) begin
                lastKind = 1;
                e.valid = 1'b1;
                e.pc = expPc;
                e.rd = ins[11:7];
                e.imm = refImm(ins);
                e.rs1Data = refRead(ins[19:15], regWr);
                e.rs2Data = refRead(ins[24:20], regWr);
                e.ctrl = refCtrl(ins, ill);
                e.illegal = ill;
                expQ.push_back(e);
            end else begin
                lastKind = 0;
            end
            if (regWr.en && regWr.addr != 5'd0) begin
                shadow[regWr.addr] = regWr.data;
            end
            if (redirect) begin
                expPc = redirectPc;
            end else if (!stall && fetchValid) begin
                expPc = expPc + 32'd4;
            end
            fetchValid = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic genInstr(output logic [31:0] w);
        int sel;
        w = $random(seed);
        sel = {$random(seed)} % 16;
        case (sel)
            0: w[6:0] = rvFrontPkg::opLoad;
            1: w[6:0] = rvFrontPkg::opFence;
            2: w[6:0] = rvFrontPkg::opArithImm;
            3: w[6:0] = rvFrontPkg::opAuipc;
            4: w[6:0] = rvFrontPkg::opStore;
            5: w[6:0] = rvFrontPkg::opArith;
            6: w[6:0] = rvFrontPkg::opLui;
            7: w[6:0] = rvFrontPkg::opBranch;
            8: w[6:0] = rvFrontPkg::opJalr;
            9: w[6:0] = rvFrontPkg::opJal;
            10: w[6:0] = rvFrontPkg::opSystem;
            11, 12: begin
                w[6:0] = rvFrontPkg::opArith;
                w[31:25] = w[25] ? 7'h20 : 7'h00;   // add/sub, srl/sra
            end
            13: begin
                w[6:0] = rvFrontPkg::opArithImm;
                w[13:12] = 2'b01;                   // slli, srli, srai
                w[31:25] = w[25] ? 7'h20 : 7'h00;
            end
            14: begin
                w[6:0] = w[7] ? rvFrontPkg::opJalr : rvFrontPkg::opSystem;
                w[14:12] = 3'd0;
            end
            default: ;                              // Mostly illegal
        endcase
    endtask

    task automatic driveCycle(input bit randomCtl);
        @(posedge clk);
        #1;
        stall = randomCtl && ({$random(seed)} % 4 == 0);
        redirect = randomCtl && ({$random(seed)} % 16 == 0);
        redirectPc = $random(seed) & 32'h0000_03fc;
        regWr.en = 1'($random(seed));
        regWr.addr = 5'($random(seed));
        regWr.data = $random(seed);
        if ({$random(seed)} % 4 == 0) begin
            regWr.addr = imemData[19:15];           // Same-cycle write and read
        end
    endtask

    initial begin
        logic [31:0] w;
        arstN = 1'b0;
        stall = 1'b0;
        redirect = 1'b0;
        redirectPc = 32'd0;
        regWr = '0;
        for (int i = 0; i < 256; i++) begin
            genInstr(w);
            imem[i] = w;
        end
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (3) @(posedge clk);
        #1 arstN = 1'b1;
        repeat (warmCycles) driveCycle(1'b0);
        repeat (randCycles) driveCycle(1'b1);
        @(posedge clk);
        #1;
        stall = 1'b1;                               // Freeze so the queue drains
        redirect = 1'b0;
        regWr = '0;
        repeat (drainCycles) @(posedge clk);
        if (expQ.size() != 0 || checkedCount == 0) begin
            $display("instructions were lost, %0d still expected", expQ.size());
            $display("TEST FAILED");
            $fatal(1, "lost instructions");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
common/rvFrontPkg.sv
fetch/fetchUnit.sv
decode/immGen.sv
decode/controller.sv
decode/fetchDecode.sv
logic/regFile.sv
logic/frontEnd.sv
verification/frontEndTb.sv
